// ==== logic/transform_pkg.sv ====
package transform_pkg;

    // --------------------
    // scalar types
    // --------------------

    typedef logic signed [15:0] coord_t;     // integer coordinate in any space
    typedef logic signed [15:0] mat_elem_t;  // rotation element, Q2.14
    typedef logic signed [15:0] depth_t;     // camera depth

    // --------------------
    // geometry
    // --------------------

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
    } triangle_t;

    typedef struct packed {
        mat_elem_t r11;
        mat_elem_t r12;
        mat_elem_t r13;
        mat_elem_t r21;
        mat_elem_t r22;
        mat_elem_t r23;
        mat_elem_t r31;
        mat_elem_t r32;
        mat_elem_t r33;
    } rot_matrix_t;

    // one combined model-to-camera transform travels with every triangle
    typedef struct packed {
        triangle_t   triangle;
        rot_matrix_t rot;
        vec3_t       pos;
    } transform_setup_t;

    // --------------------
    // pipeline constants
    // --------------------

    localparam int screen_width  = 320;
    localparam int screen_height = 240;
    localparam int focal_shift   = 8;      // focal length of 256
    localparam int near_plane    = 1;
    localparam int far_plane     = 10000;
    localparam int frac_bits     = 14;
    localparam int div_width     = 24;     // coordinate plus focal shift

    // clamps a wide intermediate into the coordinate range
    function automatic coord_t sat_coord(input logic signed [39:0] value);
        if (value > 32767) begin
            return 16'sh7fff;
        end
        if (value < -32768) begin
            return 16'sh8000;
        end
        return coord_t'(value[15:0]);
    endfunction

endpackage

// ==== logic/coord_divider.sv ====
`timescale 1ns/100ps

module coord_divider (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       start,
    input  logic signed [transform_pkg::div_width-1:0] dividend,
    input  transform_pkg::depth_t                      divisor,
    output logic                                       done,
    output transform_pkg::coord_t                      quotient
);

    logic                                       running;
    logic [$clog2(transform_pkg::div_width)-1:0] bit_cnt;

    logic                                 negative;
    logic [15:0]                          dvs;
    logic [15:0]                          rem;
    logic [transform_pkg::div_width-1:0]  quo;     // dividend bits shift out as quotient bits come in
    logic [16:0]                          rem_shift;
    logic [17:0]                          trial;
    logic signed [39:0]                   quo_wide;

    // --------------------
    // control
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                bit_cnt <= '0;
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (int'(bit_cnt) == transform_pkg::div_width - 1) begin
                    running <= 1'b0;
                    done    <= 1'b1;     // quotient valid in this cycle only
                end
            end
        end
    end

    // --------------------
    // restoring datapath
    // --------------------

    // bring down the next dividend bit and try to take the divisor out
    assign rem_shift = {rem, quo[transform_pkg::div_width-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, dvs};

    always_ff @(posedge clk) begin
        if (start) begin
            negative <= dividend[transform_pkg::div_width-1];
            quo      <= dividend[transform_pkg::div_width-1] ? -dividend : dividend;
            rem      <= '0;
            dvs      <= divisor;
        end else if (running) begin
            if (!trial[17]) begin
                rem <= trial[15:0];
                quo <= {quo[transform_pkg::div_width-2:0], 1'b1};
            end else begin
                rem <= rem_shift[15:0];      // restore because the divisor did not fit
                quo <= {quo[transform_pkg::div_width-2:0], 1'b0};
            end
        end
    end

    // magnitude division then sign gives truncation toward zero
    assign quo_wide = {16'd0, quo};
    assign quotient = transform_pkg::sat_coord(negative ? -quo_wide : quo_wide);

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start |-> !running);

endmodule

// ==== logic/vertex_transformer.sv ====
`timescale 1ns/100ps

module vertex_transformer (
    input  logic                            clk,
    input  logic                            rst,
    input  transform_pkg::transform_setup_t setup,
    input  logic                            in_valid,
    output logic                            in_ready,
    output transform_pkg::triangle_t        out_triangle,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                            busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_hold
    } state_t;

    state_t                          state;
    logic [1:0]                      vert_idx;
    transform_pkg::transform_setup_t setup_q;
    transform_pkg::vec3_t            vert_in;
    transform_pkg::vec3_t            vert_out;

    // one row of the matrix against a vertex, back to integer, plus translation
    function automatic transform_pkg::coord_t row_dot(
        input transform_pkg::mat_elem_t a,
        input transform_pkg::mat_elem_t b,
        input transform_pkg::mat_elem_t c,
        input transform_pkg::vec3_t     v,
        input transform_pkg::coord_t    offset
    );
        logic signed [33:0] acc;
        logic signed [39:0] sum;
        acc = a * v.x + b * v.y + c * v.z;
        sum = (acc >>> transform_pkg::frac_bits) + offset;  // arithmetic shift rounds down
        return transform_pkg::sat_coord(sum);
    endfunction

    always_comb begin
        case (vert_idx)
            2'd0:    vert_in = setup_q.triangle.v0;
            2'd1:    vert_in = setup_q.triangle.v1;
            default: vert_in = setup_q.triangle.v2;
        endcase
        vert_out.x = row_dot(setup_q.rot.r11, setup_q.rot.r12, setup_q.rot.r13,
                             vert_in, setup_q.pos.x);
        vert_out.y = row_dot(setup_q.rot.r21, setup_q.rot.r22, setup_q.rot.r23,
                             vert_in, setup_q.pos.y);
        vert_out.z = row_dot(setup_q.rot.r31, setup_q.rot.r32, setup_q.rot.r33,
                             vert_in, setup_q.pos.z);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            vert_idx <= 2'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        state    <= st_compute;
                        vert_idx <= 2'd0;
                    end
                end
                st_compute: begin
                    if (vert_idx == 2'd2) begin
                        state <= st_hold;    // all three vertices written
                    end else begin
                        vert_idx <= vert_idx + 2'd1;
                    end
                end
                default: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            setup_q <= setup;
        end
        if (state == st_compute) begin
            case (vert_idx)
                2'd0:    out_triangle.v0 <= vert_out;
                2'd1:    out_triangle.v1 <= vert_out;
                default: out_triangle.v2 <= vert_out;
            endcase
        end
    end

    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_hold);
    assign busy      = (state != st_idle);

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_triangle));

endmodule

// ==== logic/triangle_projector.sv ====
`timescale 1ns/100ps

module triangle_projector (
    input  logic                     clk,
    input  logic                     rst,
    input  transform_pkg::triangle_t triangle,
    input  logic                     in_valid,
    output logic                     in_ready,
    output transform_pkg::triangle_t out_triangle,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait,
        st_hold
    } state_t;

    state_t                                     state;
    logic [2:0]                                 elem_idx;    // v0.x, v0.y, v1.x ... v2.y
    transform_pkg::triangle_t                   tri_q;
    transform_pkg::triangle_t                   src;
    transform_pkg::coord_t                      sel_coord;
    transform_pkg::coord_t                      sel_z;
    logic signed [transform_pkg::div_width-1:0] dividend;
    transform_pkg::depth_t                      divisor;
    logic                                       div_start;
    logic                                       div_done;
    transform_pkg::coord_t                      quotient;
    logic signed [39:0]                         centre;
    transform_pkg::coord_t                      screen_val;

    // the first division starts in the acceptance cycle, straight from the input
    assign src = (state == st_idle) ? triangle : tri_q;

    always_comb begin
        case (elem_idx)
            3'd0:    sel_coord = src.v0.x;
            3'd1:    sel_coord = src.v0.y;
            3'd2:    sel_coord = src.v1.x;
            3'd3:    sel_coord = src.v1.y;
            3'd4:    sel_coord = src.v2.x;
            default: sel_coord = src.v2.y;
        endcase
        case (elem_idx[2:1])
            2'd0:    sel_z = src.v0.z;
            2'd1:    sel_z = src.v1.z;
            default: sel_z = src.v2.z;
        endcase
    end

    assign dividend  = sel_coord <<< transform_pkg::focal_shift;
    assign divisor   = (sel_z < transform_pkg::near_plane) ?
                       transform_pkg::depth_t'(transform_pkg::near_plane) : sel_z;
    assign div_start = (state == st_idle && in_valid) || state == st_issue;

    coord_divider u_divider (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (dividend),
        .divisor  (divisor),
        .done     (div_done),
        .quotient (quotient)
    );

    assign centre     = elem_idx[0] ? transform_pkg::screen_height / 2 :
                                      transform_pkg::screen_width / 2;
    assign screen_val = transform_pkg::sat_coord(quotient + centre);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            elem_idx <= 3'd0;
        end else begin
            case (state)
                st_idle:  if (in_valid) state <= st_wait;
                st_issue: state <= st_wait;
                st_wait: begin
                    if (div_done && elem_idx == 3'd5) begin
                        state    <= st_hold;
                        elem_idx <= 3'd0;
                    end else if (div_done) begin
                        state    <= st_issue;
                        elem_idx <= elem_idx + 3'd1;
                    end
                end
                default:  if (out_ready) state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tri_q           <= triangle;
            out_triangle.v0.z <= triangle.v0.z;    // depth passes through untouched
            out_triangle.v1.z <= triangle.v1.z;
            out_triangle.v2.z <= triangle.v2.z;
        end
        if (state == st_wait && div_done) begin
            case (elem_idx)
                3'd0:    out_triangle.v0.x <= screen_val;
                3'd1:    out_triangle.v0.y <= screen_val;
                3'd2:    out_triangle.v1.x <= screen_val;
                3'd3:    out_triangle.v1.y <= screen_val;
                3'd4:    out_triangle.v2.x <= screen_val;
                default: out_triangle.v2.y <= screen_val;
            endcase
        end
    end

    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_hold);
    assign busy      = (state != st_idle);

endmodule

// ==== logic/frustum_culler.sv ====
`timescale 1ns/100ps

module frustum_culler (
    input  logic                     clk,
    input  logic                     rst,
    input  transform_pkg::triangle_t triangle,
    input  logic                     in_valid,
    output logic                     in_ready,
    output transform_pkg::triangle_t out_triangle,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     busy
);

    logic       accept;
    logic       depth_bad;
    logic [3:0] outside;    // one bit for each screen edge that all three vertices are past
    logic       keep;

    // bits from the top are bottom, top, right, left
    function automatic logic [3:0] outcode(input transform_pkg::vec3_t v);
        return {v.y >= transform_pkg::screen_height, v.y < 0,
                v.x >= transform_pkg::screen_width,  v.x < 0};
    endfunction

    function automatic logic depth_out(input transform_pkg::vec3_t v);
        return v.z < transform_pkg::near_plane || v.z > transform_pkg::far_plane;
    endfunction

    assign depth_bad = depth_out(triangle.v0) || depth_out(triangle.v1) ||
                       depth_out(triangle.v2);
    assign outside   = outcode(triangle.v0) & outcode(triangle.v1) & outcode(triangle.v2);
    assign keep      = !depth_bad && outside == 4'b0000;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= keep;    // a culled triangle is consumed and vanishes here
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && keep) begin
            out_triangle <= triangle;
        end
    end

    assign busy = out_valid;

    a_depth_cull: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(depth_out(out_triangle.v0) || depth_out(out_triangle.v1) ||
                        depth_out(out_triangle.v2)));

endmodule

// ==== logic/transformer.sv ====
`timescale 1ns/100ps

module transformer (
    input  logic                            clk,
    input  logic                            rst,
    input  transform_pkg::transform_setup_t setup,
    input  logic                            in_valid,
    output logic                            in_ready,
    output transform_pkg::triangle_t        out_triangle,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                            busy
);

    // --------------------
    // camera space link
    // --------------------

    transform_pkg::triangle_t vt_triangle;
    logic                     vt_valid;
    logic                     vt_ready;
    logic                     vt_busy;

    vertex_transformer u_vertex_transformer (
        .clk          (clk),
        .rst          (rst),
        .setup        (setup),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_triangle (vt_triangle),
        .out_valid    (vt_valid),
        .out_ready    (vt_ready),
        .busy         (vt_busy)
    );

    // --------------------
    // screen space link
    // --------------------

    transform_pkg::triangle_t tp_triangle;    // z still holds camera depth
    logic                     tp_valid;
    logic                     tp_ready;
    logic                     tp_busy;

    triangle_projector u_triangle_projector (
        .clk          (clk),
        .rst          (rst),
        .triangle     (vt_triangle),
        .in_valid     (vt_valid),
        .in_ready     (vt_ready),
        .out_triangle (tp_triangle),
        .out_valid    (tp_valid),
        .out_ready    (tp_ready),
        .busy         (tp_busy)
    );

    logic fc_busy;

    frustum_culler u_frustum_culler (
        .clk          (clk),
        .rst          (rst),
        .triangle     (tp_triangle),
        .in_valid     (tp_valid),
        .in_ready     (tp_ready),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (fc_busy)
    );

    assign busy = vt_busy | tp_busy | fc_busy;

endmodule

// ==== tests/transform_model.svh ====
`ifndef TRANSFORM_MODEL_SVH
`define TRANSFORM_MODEL_SVH

// --------------------
// camera space
// --------------------

function automatic transform_pkg::coord_t clamp_coord(input longint value);
    if (value > 32767) begin
        return 16'sh7fff;
    end
    if (value < -32768) begin
        return 16'sh8000;
    end
    return transform_pkg::coord_t'(value);
endfunction

// one matrix row in Q2.14 floored back to an integer, then the translation
function automatic transform_pkg::coord_t rotate_row(
    input transform_pkg::mat_elem_t a,
    input transform_pkg::mat_elem_t b,
    input transform_pkg::mat_elem_t c,
    input transform_pkg::vec3_t     v,
    input transform_pkg::coord_t    offset
);
    longint dot;
    dot = longint'(a) * longint'(v.x) + longint'(b) * longint'(v.y)
        + longint'(c) * longint'(v.z);
    return clamp_coord((dot >>> transform_pkg::frac_bits) + longint'(offset));
endfunction

function automatic transform_pkg::vec3_t transform_vertex(
    input transform_pkg::vec3_t       v,
    input transform_pkg::rot_matrix_t r,
    input transform_pkg::vec3_t       pos
);
    transform_pkg::vec3_t c;
    c.x = rotate_row(r.r11, r.r12, r.r13, v, pos.x);
    c.y = rotate_row(r.r21, r.r22, r.r23, v, pos.y);
    c.z = rotate_row(r.r31, r.r32, r.r33, v, pos.z);
    return c;
endfunction

function automatic transform_pkg::triangle_t transform_triangle(
    input transform_pkg::transform_setup_t s
);
    transform_pkg::triangle_t t;
    t.v0 = transform_vertex(s.triangle.v0, s.rot, s.pos);
    t.v1 = transform_vertex(s.triangle.v1, s.rot, s.pos);
    t.v2 = transform_vertex(s.triangle.v2, s.rot, s.pos);
    return t;
endfunction

// --------------------
// screen space
// --------------------

function automatic transform_pkg::coord_t project_coord(
    input transform_pkg::coord_t c,
    input transform_pkg::coord_t z,
    input int                    centre
);
    longint den;
    longint q;
    den = (z < transform_pkg::near_plane) ? transform_pkg::near_plane : z;
    q   = (longint'(c) << transform_pkg::focal_shift) / den;    // truncates toward zero
    return clamp_coord(longint'(clamp_coord(q)) + centre);
endfunction

function automatic transform_pkg::vec3_t project_vertex(input transform_pkg::vec3_t v);
    transform_pkg::vec3_t p;
    p.x = project_coord(v.x, v.z, transform_pkg::screen_width / 2);
    p.y = project_coord(v.y, v.z, transform_pkg::screen_height / 2);
    p.z = v.z;    // camera depth rides along
    return p;
endfunction

function automatic transform_pkg::triangle_t project_triangle(
    input transform_pkg::triangle_t c
);
    transform_pkg::triangle_t t;
    t.v0 = project_vertex(c.v0);
    t.v1 = project_vertex(c.v1);
    t.v2 = project_vertex(c.v2);
    return t;
endfunction

function automatic logic depth_in_range(input transform_pkg::vec3_t v);
    return v.z >= transform_pkg::near_plane && v.z <= transform_pkg::far_plane;
endfunction

// the whole triangle goes or stays since there is no clipping
function automatic logic keep_triangle(input transform_pkg::triangle_t t);
    logic left;
    logic right;
    logic top;
    logic bottom;
    if (!(depth_in_range(t.v0) && depth_in_range(t.v1) && depth_in_range(t.v2))) begin
        return 1'b0;
    end
    left   = t.v0.x < 0 && t.v1.x < 0 && t.v2.x < 0;
    right  = t.v0.x >= transform_pkg::screen_width && t.v1.x >= transform_pkg::screen_width
             && t.v2.x >= transform_pkg::screen_width;
    top    = t.v0.y < 0 && t.v1.y < 0 && t.v2.y < 0;
    bottom = t.v0.y >= transform_pkg::screen_height && t.v1.y >= transform_pkg::screen_height
             && t.v2.y >= transform_pkg::screen_height;
    return !(left || right || top || bottom);
endfunction

`endif

// ==== tests/transformer_tb.sv ====
`timescale 1ns/100ps

module transformer_tb;

    localparam int num_directed    = 9;
    localparam int num_random      = 55;
    localparam int num_tris        = num_directed + num_random;
    localparam int watchdog_cycles = num_tris * 200 + 1000;   // projector alone takes ~160
    localparam int unit            = 1 << transform_pkg::frac_bits;

    logic                            clk;
    logic                            rst;
    transform_pkg::transform_setup_t setup;
    logic                            in_valid;
    logic                            in_ready;
    transform_pkg::triangle_t        out_triangle;
    logic                            out_valid;
    logic                            out_ready;
    logic                            busy;

    logic [31:0]                     lfsr = 32'h300f;
    transform_pkg::transform_setup_t stim [num_tris];
    int                              gap_len [num_tris];
    transform_pkg::triangle_t        exp_q [$];
    transform_pkg::triangle_t        expected_tri;
    int                              errors   = 0;
    int                              sent     = 0;
    int                              received = 0;
    int                              culled   = 0;

    `include "transform_model.svh"

    transformer UUT (
        .clk          (clk),
        .rst          (rst),
        .setup        (setup),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy)
    );

    // --------------------
    // random source
    // --------------------

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] draw(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic int signed_bits(input int n);
        logic [31:0] r;
        r = draw(n);
        if (r[n-1]) begin
            r = r | (32'hffff_ffff << n);
        end
        return int'(r);
    endfunction

    // --------------------
    // stimulus
    // --------------------

    function automatic transform_pkg::vec3_t make_vertex(input int x, input int y, input int z);
        transform_pkg::vec3_t v;
        v.x = transform_pkg::coord_t'(x);
        v.y = transform_pkg::coord_t'(y);
        v.z = transform_pkg::coord_t'(z);
        return v;
    endfunction

    function automatic transform_pkg::vec3_t pick_vertex(input logic big);
        int w;
        int x;
        int y;
        int z;
        w = big ? 16 : 9;
        x = signed_bits(w);
        y = signed_bits(w);
        z = signed_bits(w);
        return make_vertex(x, y, z);
    endfunction

    function automatic transform_pkg::rot_matrix_t exact_rot(input int kind);
        transform_pkg::rot_matrix_t r;
        r = '0;
        case (kind)
            1: begin    // quarter turn about z
                r.r12 = -unit;
                r.r21 = unit;
                r.r33 = unit;
            end
            2: begin    // half turn about y
                r.r11 = -unit;
                r.r22 = unit;
                r.r33 = -unit;
            end
            3: begin    // quarter turn about x
                r.r11 = unit;
                r.r23 = -unit;
                r.r32 = unit;
            end
            default: begin
                r.r11 = unit;
                r.r22 = unit;
                r.r33 = unit;
            end
        endcase
        return r;
    endfunction

    function automatic transform_pkg::transform_setup_t random_setup();
        transform_pkg::transform_setup_t s;
        logic                            big;
        logic [143:0]                    elems;
        logic [31:0]                     d;
        int                              i;
        big           = (draw(3) == 0);    // large vertices drive the transform into saturation
        s.triangle.v0 = pick_vertex(big);
        s.triangle.v1 = pick_vertex(big);
        s.triangle.v2 = pick_vertex(big);
        if (draw(1) == 1) begin
            s.rot = exact_rot(int'(draw(2)));
        end else begin
            elems = '0;
            for (i = 0; i < 9; i++) begin
                d     = draw(16);
                elems = {elems[127:0], d[15:0]};
            end
            s.rot = elems;
        end
        s.pos.x = transform_pkg::coord_t'(signed_bits(10));
        s.pos.y = transform_pkg::coord_t'(signed_bits(10));
        if (draw(3) == 0) begin
            s.pos.z = transform_pkg::coord_t'(signed_bits(16));   // depth anywhere so often culled
        end else begin
            s.pos.z = transform_pkg::coord_t'(300 + int'(draw(11)));
        end
        return s;
    endfunction

    task automatic build_stimulus();
        transform_pkg::transform_setup_t s;
        int                              n;
        s.rot = exact_rot(0);
        s.pos = '0;
        s.triangle = {make_vertex(10, 20, 100), make_vertex(-30, 5, 50), make_vertex(7, -9, 300)};
        stim[0] = s;
        s.triangle = {make_vertex(-13, -7, 3), make_vertex(1, 1, 1), make_vertex(100, -50, 200)};
        stim[1] = s;
        s.triangle = {make_vertex(5, 5, 0), make_vertex(10, 10, 100), make_vertex(20, 20, 100)};
        stim[2] = s;
        s.triangle = {make_vertex(5, 5, 10001), make_vertex(1, 1, 90), make_vertex(2, 2, 90)};
        stim[3] = s;
        s.triangle = {make_vertex(5, 5, 1), make_vertex(0, 0, 10000), make_vertex(3, 4, 64)};
        stim[4] = s;
        // all left of the screen, then the same with one vertex pulled inside
        s.triangle = {make_vertex(-100, 0, 50), make_vertex(-200, 10, 60), make_vertex(-90, -20, 40)};
        stim[5] = s;
        s.triangle = {make_vertex(-100, 0, 50), make_vertex(0, 0, 100), make_vertex(-90, -20, 40)};
        stim[6] = s;
        s.triangle = {make_vertex(0, 100, 100), make_vertex(10, 200, 100), make_vertex(-10, 50, 50)};
        stim[7] = s;
        // every vertex off screen but past different edges
        s.triangle = {make_vertex(-100, 0, 50), make_vertex(100, 0, 50), make_vertex(0, -100, 50)};
        stim[8] = s;
        for (n = 0; n < num_directed; n++) begin
            gap_len[n] = 0;
        end
        for (n = num_directed; n < num_tris; n++) begin
            stim[n]    = random_setup();
            gap_len[n] = (draw(2) == 0) ? int'(draw(3)) : 0;
        end
    endtask

    task automatic send_setup(input transform_pkg::transform_setup_t s, input int gap);
        transform_pkg::triangle_t screen;
        repeat (gap) @(negedge clk);
        setup    = s;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        screen = project_triangle(transform_triangle(s));
        if (keep_triangle(screen)) begin
            exp_q.push_back(screen);
        end else begin
            culled++;
        end
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // --------------------
    // clock, stalls, output checks
    // --------------------

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        out_ready = 1'b0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            out_ready = (draw(2) != 0);    // stalls about a quarter of the cycles
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            received++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("triangle came out at %0t while none was expected", $time);
            end else begin
                expected_tri = exp_q.pop_front();
                if (out_triangle !== expected_tri) begin
                    errors++;
                    $display("mismatch at %0t: got %h, expected %h",
                             $time, out_triangle, expected_tri);
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, pipeline stopped moving", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int n;
        int wait_cycles;
        rst      = 1'b1;
        in_valid = 1'b0;
        setup    = '0;
        build_stimulus();
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (out_valid || busy || !in_ready) begin
            errors++;
            $display("DUT not idle after reset: out_valid %b busy %b in_ready %b",
                     out_valid, busy, in_ready);
        end
        rst = 1'b0;
        for (n = 0; n < num_tris; n++) begin
            send_setup(stim[n], gap_len[n]);
        end
        wait_cycles = 0;
        while ((exp_q.size() != 0 || busy) && wait_cycles < 1000) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected triangles never came out", exp_q.size());
        end
        if (busy) begin
            errors++;
            $display("busy is still high after the pipeline drained");
        end
        if (received + culled != sent) begin
            errors++;
            $display("received %0d plus culled %0d does not add up to %0d sent",
                     received, culled, sent);
        end
        $display("summary: %0d sent, %0d received, %0d culled, %0d errors",
                 sent, received, culled, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tests
logic/transform_pkg.sv
logic/coord_divider.sv
logic/vertex_transformer.sv
logic/triangle_projector.sv
logic/frustum_culler.sv
logic/transformer.sv
tests/transformer_tb.sv
